//--- files.f
logic/isaPkg.sv
logic/busPkg.sv
logic/instrDecode.sv
logic/alu.sv
logic/regFile.sv
logic/coreControl.sv
logic/rvCore.sv
verification/tbClock.sv
verification/tbTop.sv

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
   input  isaPkg::aluOp_t op,
   input  isaPkg::word_t  a,
   input  isaPkg::word_t  b,
   output isaPkg::word_t  result
);

   logic [4:0] shamt;

   assign shamt = b[4:0]; // RV32I ignores upper shift bits

   always_comb begin
      case (op)
         isaPkg::ALU_ADD:   result = a + b;
         isaPkg::ALU_SUB:   result = a - b;
         isaPkg::ALU_SLL:   result = a << shamt;
         isaPkg::ALU_SRL:   result = a >> shamt;
         isaPkg::ALU_SRA:   result = $signed(a) >>> shamt;
         isaPkg::ALU_OR:    result = a | b;
         isaPkg::ALU_AND:   result = a & b;
         isaPkg::ALU_PASSB: result = b; // LUI
         default:           result = '0;
      endcase
   end

endmodule

//--- logic/busPkg.sv
package busPkg;

   localparam int ADDR_W = 32;

   typedef logic [ADDR_W-1:0] addr_t;

   // Byte distance between instruction words
   localparam addr_t PC_STEP = 32'd4;

   typedef struct packed {
      logic          valid;
      logic          write;
      addr_t         addr;
      isaPkg::word_t wdata;
   } memReq_t;

   typedef struct packed {
      logic          valid; // Single cycle pulse
      isaPkg::word_t rdata;
   } memRsp_t;

endpackage

//--- logic/coreControl.sv
`timescale 1ns/1ps

module coreControl (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  start,
   output busPkg::memReq_t       memReq,
   input  busPkg::memRsp_t       memRsp,
   output logic                  halt,
   output isaPkg::word_t         instr,
   input  isaPkg::decodedInstr_t dec,
   input  isaPkg::word_t         aluResult,
   input  isaPkg::word_t         rs2Data,
   output logic                  wrEn,
   output isaPkg::regIdx_t       wrIdx,
   output isaPkg::word_t         wrData
);

   typedef enum logic [1:0] {
      HALTED,
      FETCH,
      EXECUTE,
      MEMWAIT
   } state_t;

   state_t          state;
   busPkg::addr_t   pc;
   isaPkg::word_t   ir;
   isaPkg::regIdx_t loadRd;
   logic            reqValid;
   logic            reqWrite;
   busPkg::addr_t   reqAddr;
   isaPkg::word_t   reqWdata;
   logic            memAccess;

   assign memAccess = dec.isLoad || dec.isStore;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state    <= HALTED;
         pc       <= '0;
         ir       <= '0;
         reqValid <= 1'b0;
         halt     <= 1'b1;
      end else begin
         case (state)
            HALTED: begin
               if (start) begin
                  state <= FETCH;
                  halt  <= 1'b0;
               end
            end
            FETCH: begin
               if (!reqValid) begin
                  reqValid <= 1'b1; // Request goes out one cycle after entry
               end else if (memRsp.valid) begin
                  reqValid <= 1'b0;
                  ir       <= memRsp.rdata;
                  state    <= EXECUTE;
               end
            end
            EXECUTE: begin
               pc <= pc + busPkg::PC_STEP;
               if (dec.isHalt) begin
                  state <= HALTED;
                  halt  <= 1'b1;
               end else if (memAccess) begin
                  reqValid <= 1'b1;
                  state    <= MEMWAIT;
               end else begin
                  state <= FETCH;
               end
            end
            MEMWAIT: begin
               if (memRsp.valid) begin
                  reqValid <= 1'b0;
                  state    <= FETCH;
               end
            end
            default: state <= HALTED;
         endcase
      end
   end

   // Request payload, held while valid is high
   always_ff @(posedge clk) begin
      if (state == FETCH && !reqValid) begin
         reqWrite <= 1'b0;
         reqAddr  <= pc;
         reqWdata <= '0;
      end else if (state == EXECUTE && memAccess) begin
         reqWrite <= dec.isStore;
         reqAddr  <= aluResult;
         reqWdata <= rs2Data;
         loadRd   <= dec.rd;
      end
   end

   assign memReq = '{valid: reqValid, write: reqWrite, addr: reqAddr, wdata: reqWdata};
   assign instr  = ir;

   // Write-back from the ALU in EXECUTE, or from read data on a load response
   assign wrEn   = (state == EXECUTE && dec.regWrite && !dec.isLoad) ||
                   (state == MEMWAIT && memRsp.valid && !reqWrite);
   assign wrIdx  = (state == MEMWAIT) ? loadRd : dec.rd;
   assign wrData = (state == MEMWAIT) ? memRsp.rdata : aluResult;

   aReqStable: assert property (@(posedge clk) disable iff (!rstn)
      (memReq.valid && !memRsp.valid) |=> (memReq.valid && $stable(memReq)))
      else $error("Memory request changed before its response");

   aReqAligned: assert property (@(posedge clk) disable iff (!rstn)
      memReq.valid |-> (memReq.addr[1:0] == 2'b00))
      else $error("Unaligned memory request address");

endmodule

//--- logic/instrDecode.sv
`timescale 1ns/1ps

module instrDecode (
   input  isaPkg::word_t         instr,
   output isaPkg::decodedInstr_t dec
);

   logic [6:0]    opcode;
   logic [2:0]    funct3;
   logic [6:0]    funct7;
   isaPkg::word_t immI;
   isaPkg::word_t immS;
   isaPkg::word_t immU;

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign funct7 = instr[31:25];

   assign immI = {{20{instr[31]}}, instr[31:20]};
   assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {instr[31:12], 12'h000};

   always_comb begin
      dec       = '0;
      dec.aluOp = isaPkg::ALU_ADD;
      dec.rs1   = instr[19:15];
      dec.rs2   = instr[24:20];
      dec.rd    = instr[11:7];

      // Anything not matched below stays a no-op
      case (opcode)
         isaPkg::OPC_LUI: begin
            dec.aluOp    = isaPkg::ALU_PASSB;
            dec.imm      = immU;
            dec.useImm   = 1'b1;
            dec.regWrite = 1'b1;
         end
         isaPkg::OPC_OPIMM: begin
            dec.imm    = immI;
            dec.useImm = 1'b1;
            case (funct3)
               isaPkg::F3_OR: begin
                  dec.aluOp    = isaPkg::ALU_OR;
                  dec.regWrite = 1'b1;
               end
               isaPkg::F3_AND: begin
                  dec.aluOp    = isaPkg::ALU_AND;
                  dec.regWrite = 1'b1;
               end
               isaPkg::F3_SLL: begin
                  dec.aluOp    = isaPkg::ALU_SLL;
                  dec.regWrite = (funct7 == isaPkg::F7_BASE);
               end
               isaPkg::F3_SR: begin
                  dec.aluOp    = (funct7 == isaPkg::F7_ALT) ? isaPkg::ALU_SRA : isaPkg::ALU_SRL;
                  dec.regWrite = (funct7 == isaPkg::F7_BASE) || (funct7 == isaPkg::F7_ALT);
               end
               default: dec.regWrite = 1'b0; // ADDI and friends not supported
            endcase
         end
         isaPkg::OPC_OP: begin
            if (funct3 == isaPkg::F3_ADDSUB && funct7 == isaPkg::F7_BASE) begin
               dec.aluOp    = isaPkg::ALU_ADD;
               dec.regWrite = 1'b1;
            end else if (funct3 == isaPkg::F3_ADDSUB && funct7 == isaPkg::F7_ALT) begin
               dec.aluOp    = isaPkg::ALU_SUB;
               dec.regWrite = 1'b1;
            end else if (funct3 == isaPkg::F3_SLL && funct7 == isaPkg::F7_BASE) begin
               dec.aluOp    = isaPkg::ALU_SLL;
               dec.regWrite = 1'b1;
            end
         end
         isaPkg::OPC_LOAD: begin
            dec.imm      = immI;
            dec.useImm   = 1'b1;
            dec.isLoad   = (funct3 == isaPkg::F3_WORD);
            dec.regWrite = (funct3 == isaPkg::F3_WORD); // Written on data response
         end
         isaPkg::OPC_STORE: begin
            dec.imm     = immS;
            dec.useImm  = 1'b1;
            dec.isStore = (funct3 == isaPkg::F3_WORD);
         end
         isaPkg::OPC_HALT: dec.isHalt = 1'b1;
         default: dec.regWrite = 1'b0;
      endcase
   end

endmodule

//--- logic/isaPkg.sv
package isaPkg;

   localparam int XLEN     = 32;
   localparam int NUM_REGS = 32;

   typedef logic [XLEN-1:0] word_t;
   typedef logic [4:0]      regIdx_t;

   // Major opcodes
   localparam logic [6:0] OPC_OPIMM = 7'b0010011;
   localparam logic [6:0] OPC_OP    = 7'b0110011;
   localparam logic [6:0] OPC_LUI   = 7'b0110111;
   localparam logic [6:0] OPC_LOAD  = 7'b0000011;
   localparam logic [6:0] OPC_STORE = 7'b0100011;
   localparam logic [6:0] OPC_HALT  = 7'b1111111; // Custom stop code

   localparam logic [2:0] F3_ADDSUB = 3'b000;
   localparam logic [2:0] F3_SLL    = 3'b001;
   localparam logic [2:0] F3_WORD   = 3'b010; // LW and SW width
   localparam logic [2:0] F3_SR     = 3'b101;
   localparam logic [2:0] F3_OR     = 3'b110;
   localparam logic [2:0] F3_AND    = 3'b111;

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRAI

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      ALU_OR,
      ALU_AND,
      ALU_PASSB
   } aluOp_t;

   typedef struct packed {
      aluOp_t  aluOp;
      regIdx_t rs1;
      regIdx_t rs2;
      regIdx_t rd;
      word_t   imm;      // Already sign extended
      logic    useImm;   // Operand B from imm
      logic    regWrite;
      logic    isLoad;
      logic    isStore;
      logic    isHalt;
   } decodedInstr_t;

endpackage

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic            clk,
   input  logic            rstn,
   input  isaPkg::regIdx_t rdIdxA,
   input  isaPkg::regIdx_t rdIdxB,
   output isaPkg::word_t   rdDataA,
   output isaPkg::word_t   rdDataB,
   input  logic            wrEn,
   input  isaPkg::regIdx_t wrIdx,
   input  isaPkg::word_t   wrData
);

   isaPkg::word_t regs [isaPkg::NUM_REGS];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < isaPkg::NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn && wrIdx != '0) begin
         regs[wrIdx] <= wrData;
      end
   end

   // x0 reads as zero
   assign rdDataA = (rdIdxA == '0) ? '0 : regs[rdIdxA];
   assign rdDataB = (rdIdxB == '0) ? '0 : regs[rdIdxB];

   aZeroReg: assert property (@(posedge clk) disable iff (!rstn) regs[0] == '0)
      else $error("x0 holds a nonzero value");

endmodule

//--- logic/rvCore.sv
`timescale 1ns/1ps

module rvCore (
   input  logic            clk,
   input  logic            rstn,
   input  logic            start,
   output busPkg::memReq_t memReq,
   input  busPkg::memRsp_t memRsp,
   output logic            halt
);

   isaPkg::word_t         instr;
   isaPkg::decodedInstr_t dec;
   isaPkg::word_t         rs1Data;
   isaPkg::word_t         rs2Data;
   isaPkg::word_t         aluB;
   isaPkg::word_t         aluResult;
   logic                  wrEn;
   isaPkg::regIdx_t       wrIdx;
   isaPkg::word_t         wrData;

   coreControl uCtrl (
      .clk       (clk),
      .rstn      (rstn),
      .start     (start),
      .memReq    (memReq),
      .memRsp    (memRsp),
      .halt      (halt),
      .instr     (instr),
      .dec       (dec),
      .aluResult (aluResult),
      .rs2Data   (rs2Data),
      .wrEn      (wrEn),
      .wrIdx     (wrIdx),
      .wrData    (wrData)
   );

   instrDecode uDec (
      .instr (instr),
      .dec   (dec)
   );

   assign aluB = dec.useImm ? dec.imm : rs2Data; // Operand B select

   alu uAlu (
      .op     (dec.aluOp),
      .a      (rs1Data),
      .b      (aluB),
      .result (aluResult)
   );

   regFile uRegs (
      .clk     (clk),
      .rstn    (rstn),
      .rdIdxA  (dec.rs1),
      .rdIdxB  (dec.rs2),
      .rdDataA (rs1Data),
      .rdDataB (rs2Data),
      .wrEn    (wrEn),
      .wrIdx   (wrIdx),
      .wrData  (wrData)
   );

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tbTop -f files.f -o simv
./obj_dir/simv | tee sim.log

if ! grep -qx "TEST OK" sim.log; then
   echo "Simulation did not pass, see sim.log"
   exit 1
fi

//--- verification/golden_program.txt
// kind address data: 1 program word, 2 initial data word, 3 expected store in order
1 00000000 123450B7
1 00000004 FFF06113
1 00000008 6780E193
1 0000000C FF01F213
1 00000010 004182B3
1 00000014 40320333
1 00000018 02306393
1 0000001C 00719433
1 00000020 00431493
1 00000024 40235513
1 00000028 01C35593
1 0000002C 20006613
1 00000030 00162023
1 00000034 00262223
1 00000038 00362423
1 0000003C 00462623
1 00000040 00562823
1 00000044 00662A23
1 00000048 00862C23
1 0000004C 00962E23
1 00000050 02A62023
1 00000054 02B62223
1 00000058 10002083
1 0000005C 0FF0F113
1 00000060 02262423
1 00000064 05506013
1 00000068 02062623
1 0000006C FFF1610B
1 00000070 02262823
1 00000074 0000007F
2 00000100 CAFEF00D
3 00000200 12345000
3 00000204 FFFFFFFF
3 00000208 12345678
3 0000020C 12345670
3 00000210 2468ACE8
3 00000214 FFFFFFF8
3 00000218 91A2B3C0
3 0000021C FFFFFF80
3 00000220 FFFFFFFE
3 00000224 0000000F
3 00000228 0000000D
3 0000022C 00000000
3 00000230 0000000D

//--- verification/tbClock.sv
`timescale 1ns/1ps

module tbClock (
   output logic clk,
   output logic rstn
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk; // 10 ns period
   end

   // Reset held for two rising edges, released on a falling edge
   initial begin
      rstn = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
   end

endmodule

//--- verification/tbTop.sv
`timescale 1ns/1ps

module tbTop;

   localparam int MEM_WORDS = 1024;
   localparam int MAX_RECS  = 128;

   logic            clk;
   logic            rstn;
   logic            start;
   busPkg::memReq_t memReq;
   busPkg::memRsp_t memRsp = '0;
   logic            halt;

   isaPkg::word_t   golden [0:3*MAX_RECS-1];
   isaPkg::word_t   mem [0:MEM_WORDS-1];
   busPkg::addr_t   expAddr [$];
   isaPkg::word_t   expData [$];
   int              progWords = 0;
   int              dataAccesses = 0;
   int              reqCount = 0;
   int              valueErrors = 0;
   int              protocolErrors = 0;
   int              seed = 33;
   int              delay = 0;
   logic            busy = 1'b0;
   busPkg::memReq_t heldReq;

   tbClock uClk (.clk(clk), .rstn(rstn));

   rvCore u_dut (
      .clk    (clk),
      .rstn   (rstn),
      .start  (start),
      .memReq (memReq),
      .memRsp (memRsp),
      .halt   (halt)
   );

   task automatic checkValue(input string name, input isaPkg::word_t exp, input isaPkg::word_t act);
      assert (act === exp) else begin
         valueErrors++;
         $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   // Records are kind, byte address, data
   task automatic loadGolden();
      isaPkg::word_t kind;
      isaPkg::word_t addr;
      isaPkg::word_t data;
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = 32'h5EED0000 ^ (i << 2);
      end
      for (int i = 0; i < 3*MAX_RECS; i++) begin
         golden[i] = '0;
      end
      $readmemh("verification/golden_program.txt", golden);
      for (int r = 0; r < MAX_RECS; r++) begin
         kind = golden[3*r];
         addr = golden[3*r+1];
         data = golden[3*r+2];
         if (kind == 32'd1) begin
            mem[addr[11:2]] = data;
            progWords++;
            if ((data[6:0] == isaPkg::OPC_LOAD || data[6:0] == isaPkg::OPC_STORE) &&
                data[14:12] == isaPkg::F3_WORD) begin
               dataAccesses++;
            end
         end else if (kind == 32'd2) begin
            mem[addr[11:2]] = data;
         end else if (kind == 32'd3) begin
            expAddr.push_back(addr);
            expData.push_back(data);
         end
      end
   endtask

   task automatic checkRequest(input busPkg::memReq_t req);
      assert (req.addr[1:0] == 2'b00 && req.addr[31:12] == '0) else begin
         protocolErrors++;
         $display("Request address %h is unaligned or outside the memory", req.addr);
      end
      if (req.write) begin
         assert (expAddr.size() > 0) else begin
            protocolErrors++;
            $display("Store to %h arrived after all expected stores", req.addr);
         end
         if (expAddr.size() > 0) begin
            checkValue("memReq.addr", expAddr.pop_front(), req.addr);
            checkValue("memReq.wdata", expData.pop_front(), req.wdata);
         end
      end
   endtask

   // Memory model, one request at a time with a random wait
   always @(negedge clk) begin
      memRsp = '0;
      if (rstn && memReq.valid) begin
         if (!busy) begin
            busy    = 1'b1;
            heldReq = memReq;
            delay   = $unsigned($random(seed)) % 4;
            reqCount++;
            checkRequest(memReq);
         end else begin
            assert (memReq == heldReq) else begin
               protocolErrors++;
               $display("FAIL t=%0t memReq expected %h actual %h", $time, heldReq, memReq);
            end
         end
         if (delay == 0) begin
            memRsp.valid = 1'b1;
            memRsp.rdata = heldReq.write ? '0 : mem[heldReq.addr[11:2]];
            if (heldReq.write) begin
               mem[heldReq.addr[11:2]] = heldReq.wdata;
            end
            busy = 1'b0;
         end else begin
            delay--;
         end
      end else begin
         assert (!busy) else begin
            protocolErrors++;
            $display("Request dropped before its response at %0t", $time);
         end
         busy = 1'b0;
      end
   end

   initial begin
      start = 1'b0;
      loadGolden();
      @(posedge rstn);
      repeat (4) begin
         @(negedge clk);
         assert (halt && !memReq.valid) else begin
            protocolErrors++;
            $display("Core left the halted state before start");
         end
      end
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
      while (!halt) @(negedge clk);
      repeat (20) begin
         @(negedge clk);
         assert (!memReq.valid) else begin
            protocolErrors++;
            $display("Request issued after halt at %0t", $time);
         end
      end
      assert (expAddr.size() == 0) else begin
         protocolErrors++;
         $display("%0d expected stores never happened", expAddr.size());
      end
      checkValue("request count", progWords + dataAccesses, reqCount);
      $display("Requests %0d, value errors %0d, protocol errors %0d",
               reqCount, valueErrors, protocolErrors);
      if (valueErrors == 0 && protocolErrors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

   // Watchdog scaled by program length
   initial begin
      @(posedge rstn);
      repeat (200 * progWords) @(posedge clk);
      $display("Watchdog expired before the core halted");
      $display("TEST FAILED");
      $finish;
   end

endmodule
